//--- design/clkgen_pkg.sv
// Clock generator package with command format, channel configuration and field widths
package clkgen_pkg;

    // Divisor width, counts i_clk cycles per half-period
    localparam int DIV_W = 16;

    // Channel index width, room for up to four channels
    localparam int CH_W = 2;

    // Command opcodes
    typedef enum logic [1:0] {
        OP_SET_DIV = 2'd0,
        OP_SET_CTL = 2'd1
    } cmd_op_e;

    // Control word carried in the payload, enable in bit 0
    typedef struct packed {
        logic [DIV_W-3:0] rsvd;
        logic             invert;
        logic             enable;
    } ctl_t;

    // Same 16 payload bits, read as a divisor or as control
    // depending on the opcode
    typedef union packed {
        logic [DIV_W-1:0] div;
        ctl_t             ctl;
    } cmd_payload_u;

    // One queued command
    typedef struct packed {
        cmd_op_e          op;
        logic [CH_W-1:0]  ch;
        cmd_payload_u     payload;
    } cmd_t;

    // Live configuration of one divider channel
    typedef struct packed {
        logic [DIV_W-1:0] div;
        logic             enable;
        logic             invert;
    } chan_cfg_t;

endpackage

//--- design/cmd_fifo.sv
// Command queue with credit return per pop and a sticky overflow flag
`timescale 1ns/1ps

module cmd_fifo #(
    parameter int CMD_DEPTH = 4
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_cmd_valid,
    input  clkgen_pkg::cmd_t i_cmd,
    input  logic             i_pop,
    output clkgen_pkg::cmd_t o_head,
    output logic             o_not_empty,
    output logic             o_credit,
    output logic             o_overflow
);

    localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CNT_W = $clog2(CMD_DEPTH + 1);

    clkgen_pkg::cmd_t mem [CMD_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    // Circular pointer advance
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        ptr_inc = (p == PTR_W'(CMD_DEPTH - 1)) ? '0 : p + PTR_W'(1);
    endfunction

    assign full        = (count == CNT_W'(CMD_DEPTH));
    assign o_not_empty = (count != '0);
    // A write into a full queue is lost
    assign wr_en       = i_cmd_valid & ~full;
    assign rd_en       = i_pop & o_not_empty;
    assign o_head      = mem[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_cmd;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            o_credit   <= 1'b0;
            o_overflow <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
            // One credit back for every command taken
            o_credit <= rd_en;
            if (i_cmd_valid && full) begin
                o_overflow <= 1'b1;
            end
        end
    end

endmodule

//--- design/clkgen_regs.sv
// Command decoder holding per-channel divisor, enable and polarity with deferred divisor updates
`timescale 1ns/1ps

module clkgen_regs #(
    parameter int NUM_CH = 4
) (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  clkgen_pkg::cmd_t                   i_head,
    input  logic                               i_not_empty,
    output logic                               o_pop,
    output clkgen_pkg::chan_cfg_t [NUM_CH-1:0] o_cfg,
    input  logic [NUM_CH-1:0]                  i_toggle
);

    localparam logic [clkgen_pkg::DIV_W-1:0] DIV_RST = 1;

    logic [NUM_CH-1:0]        pend;
    clkgen_pkg::cmd_payload_u payload;
    logic                     is_div;
    logic                     is_ctl;

    assign payload = i_head.payload;
    assign is_div  = (i_head.op == clkgen_pkg::OP_SET_DIV);
    assign is_ctl  = (i_head.op == clkgen_pkg::OP_SET_CTL);

    // Queue is held while any channel still waits for its toggle
    assign o_pop = i_not_empty & ~(|pend);

    for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
        clkgen_pkg::chan_cfg_t        cfg_q;
        logic                         pend_q;
        logic [clkgen_pkg::DIV_W-1:0] pend_div;
        logic                         hit;

        // Out-of-range channel indices match no entry and are dropped
        assign hit = o_pop & (int'(i_head.ch) == g);

        // Divisor waiting for the channel's next edge
        always_ff @(posedge i_clk) begin
            if (hit && is_div) begin
                pend_div <= payload.div;
            end
        end

        always_ff @(posedge i_clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                cfg_q  <= '{div: DIV_RST, enable: 1'b0, invert: 1'b0};
                pend_q <= 1'b0;
            end else if (hit && is_div) begin
                // Running channel waits for a toggle, an idle one takes it now
                if (cfg_q.enable) begin
                    pend_q <= 1'b1;
                end else begin
                    cfg_q.div <= payload.div;
                end
            end else if (hit && is_ctl) begin
                // Reserved control bits are ignored
                cfg_q.enable <= payload.ctl.enable;
                cfg_q.invert <= payload.ctl.invert;
            end else if (pend_q && i_toggle[g]) begin
                cfg_q.div <= pend_div;
                pend_q    <= 1'b0;
            end
        end

        assign o_cfg[g] = cfg_q;
        assign pend[g]  = pend_q;
    end

endmodule

//--- design/clk_divider.sv
// Programmable divider channel, two-stage compare pipeline producing a square wave
`timescale 1ns/1ps

module clk_divider #(
    parameter int DIV_W = clkgen_pkg::DIV_W
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  clkgen_pkg::chan_cfg_t i_cfg,
    output logic                  o_toggle,
    output logic                  o_clk
);

    // Stage 1 copy of the configuration
    logic [DIV_W-1:0] div_q;
    logic             en_q;
    logic             inv_q;

    // Stage 2 counter and terminal count
    logic [DIV_W-1:0] cnt_q;
    logic [DIV_W-1:0] cnt_nxt;
    logic [DIV_W-1:0] div_m1;
    logic             tc_q;

    logic             flip;
    logic             phase_q;
    logic             phase_nxt;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            div_q <= DIV_W'(1);
            en_q  <= 1'b0;
            inv_q <= 1'b0;
        end else begin
            div_q <= i_cfg.div;
            en_q  <= i_cfg.enable;
            inv_q <= i_cfg.invert;
        end
    end

    // Divisor 0 behaves as 1
    assign div_m1 = (div_q == '0) ? '0 : div_q - DIV_W'(1);

    assign flip    = tc_q & en_q;
    assign cnt_nxt = flip ? '0 : cnt_q + DIV_W'(1);

    // Compare on the next count so tc_q lines up with the count reaching D-1
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q <= '0;
            tc_q  <= 1'b0;
        end else if (!en_q) begin
            cnt_q <= '0;
            tc_q  <= 1'b0;
        end else begin
            cnt_q <= cnt_nxt;
            tc_q  <= (cnt_nxt >= div_m1);
        end
    end

    // Phase returns to 0 whenever the channel is off
    assign phase_nxt = en_q & (phase_q ^ flip);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase_q <= 1'b0;
            o_clk   <= 1'b0;
        end else begin
            phase_q <= phase_nxt;
            o_clk   <= phase_nxt ^ inv_q;
        end
    end

    // High in the cycle whose closing edge flips the phase
    assign o_toggle = flip;

endmodule

//--- design/clkgen_top.sv
// Clock-enable generator top with command queue, register block and divider channels
`timescale 1ns/1ps

module clkgen_top #(
    parameter int NUM_CH    = 4,
    parameter int CMD_DEPTH = 4
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_cmd_valid,
    input  clkgen_pkg::cmd_t  i_cmd,
    output logic              o_credit,
    output logic              o_overflow,
    output logic [NUM_CH-1:0] o_clk
);

    clkgen_pkg::cmd_t                   head;
    logic                               not_empty;
    logic                               pop;
    clkgen_pkg::chan_cfg_t [NUM_CH-1:0] cfg;
    logic [NUM_CH-1:0]                  toggle;

    cmd_fifo #(
        .CMD_DEPTH (CMD_DEPTH)
    ) u_fifo (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd       (i_cmd),
        .i_pop       (pop),
        .o_head      (head),
        .o_not_empty (not_empty),
        .o_credit    (o_credit),
        .o_overflow  (o_overflow)
    );

    clkgen_regs #(
        .NUM_CH (NUM_CH)
    ) u_regs (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_head      (head),
        .i_not_empty (not_empty),
        .o_pop       (pop),
        .o_cfg       (cfg),
        .i_toggle    (toggle)
    );

    // One divider per channel
    for (genvar g = 0; g < NUM_CH; g++) begin : g_div
        clk_divider #(
            .DIV_W (clkgen_pkg::DIV_W)
        ) u_div (
            .i_clk    (i_clk),
            .i_rst_n  (i_rst_n),
            .i_cfg    (cfg[g]),
            .o_toggle (toggle[g]),
            .o_clk    (o_clk[g])
        );
    end

endmodule

//--- tb/tb_clkgen.sv
// Self-checking testbench for the clock-enable generator, driven by a command file
`timescale 1ns/1ps

module tb_clkgen;

    localparam int NUM_CH       = 4;
    localparam int CMD_DEPTH    = 4;
    localparam int WAIT_LIMIT   = 2000;
    localparam int EDGE_LIMIT   = 1000;
    localparam int GLITCH_HALFS = 4;
    localparam int HOLD_CYCLES  = 8;
    localparam int SETTLE       = 4;

    logic              i_clk;
    logic              i_rst_n;
    logic              i_cmd_valid;
    clkgen_pkg::cmd_t  i_cmd;
    logic              o_credit;
    logic              o_overflow;
    logic [NUM_CH-1:0] o_clk;

    int     credit_pulses;
    int     cmds_sent;
    integer seed;

    // Level last seen on each output and cycles since it changed
    logic [NUM_CH-1:0] clk_seen;
    int                clk_age [NUM_CH];

    clkgen_top #(
        .NUM_CH    (NUM_CH),
        .CMD_DEPTH (CMD_DEPTH)
    ) u_dut (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd       (i_cmd),
        .o_credit    (o_credit),
        .o_overflow  (o_overflow),
        .o_clk       (o_clk)
    );

    always #10 i_clk = ~i_clk;

    // Credits counted mid-cycle, read by the sender on the rising edge
    always @(negedge i_clk) begin
        if (o_credit) begin
            credit_pulses <= credit_pulses + 1;
        end
    end

    always @(negedge i_clk) begin
        for (int c = 0; c < NUM_CH; c++) begin
            if (o_clk[c] !== clk_seen[c]) begin
                clk_seen[c] <= o_clk[c];
                clk_age[c]  <= 0;
            end else begin
                clk_age[c] <= clk_age[c] + 1;
            end
        end
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s expected %0d actual %0d", name, expected, actual);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    function automatic clkgen_pkg::cmd_t build_cmd(input int ch, input int op, input int value);
        clkgen_pkg::cmd_t c;
        logic [31:0]      rnd;
        c             = '0;
        c.op          = clkgen_pkg::cmd_op_e'(op[1:0]);
        c.ch          = ch[clkgen_pkg::CH_W-1:0];
        c.payload.div = value[clkgen_pkg::DIV_W-1:0];
        if (c.op == clkgen_pkg::OP_SET_CTL) begin
            // Noise in the reserved control bits
            rnd                = $random(seed);
            c.payload.ctl.rsvd = rnd[clkgen_pkg::DIV_W-3:0];
        end
        return c;
    endfunction

    task automatic send_cmd(input clkgen_pkg::cmd_t c);
        int waited;
        waited = 0;
        @(posedge i_clk);
        while (CMD_DEPTH - (cmds_sent - credit_pulses) <= 0) begin
            if (waited >= WAIT_LIMIT) begin
                abort_run("Timeout: no credit came back for the next command");
            end
            waited++;
            @(posedge i_clk);
        end
        i_cmd_valid <= 1'b1;
        i_cmd       <= c;
        cmds_sent++;
        @(posedge i_clk);
        i_cmd_valid <= 1'b0;
    endtask

    // Back to back writes with no regard for credits
    task automatic send_burst(input clkgen_pkg::cmd_t c, input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge i_clk);
            i_cmd_valid <= 1'b1;
            i_cmd       <= c;
            cmds_sent++;
        end
        @(posedge i_clk);
        i_cmd_valid <= 1'b0;
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        @(posedge i_clk);
        while (credit_pulses != cmds_sent) begin
            if (waited >= WAIT_LIMIT) begin
                abort_run("Timeout: the command queue did not drain, credits are missing");
            end
            waited++;
            @(posedge i_clk);
        end
    endtask

    // Called on a falling edge, counts cycles to the next change of o_clk
    task automatic measure_half(input int ch, output int cycles);
        logic prev;
        int   n;
        prev = o_clk[ch];
        @(negedge i_clk);
        n = 1;
        while (o_clk[ch] === prev) begin
            if (n >= EDGE_LIMIT) begin
                abort_run($sformatf("Timeout: channel %0d output stopped toggling", ch));
            end
            @(negedge i_clk);
            n++;
        end
        cycles = n;
    endtask

    task automatic check_half_periods(input int ch, input int count, input int expected);
        int hp;
        wait_for_drain();
        // Let the config pipeline catch up
        repeat (SETTLE) @(negedge i_clk);
        measure_half(ch, hp);
        for (int i = 0; i < count; i++) begin
            measure_half(ch, hp);
            check_value($sformatf("half period ch%0d #%0d", ch, i), expected, hp);
        end
    endtask

    task automatic check_level(input int ch, input int expected);
        int n;
        wait_for_drain();
        @(negedge i_clk);
        n = 1;
        while (o_clk[ch] !== expected[0] && n < 3) begin
            @(negedge i_clk);
            n++;
        end
        check_value($sformatf("idle level ch%0d", ch), expected, o_clk[ch]);
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(negedge i_clk);
            check_value($sformatf("idle hold ch%0d", ch), expected, o_clk[ch]);
        end
    endtask

    // Half period in progress when the command lands is measured whole
    // Only the first half after it may still run at the old divisor
    task automatic check_div_change(input int ch, input int old_div, input int new_div);
        int   hp;
        logic prev;
        hp   = clk_age[ch];
        prev = clk_seen[ch];
        @(negedge i_clk);
        hp++;
        while (o_clk[ch] === prev) begin
            if (hp >= EDGE_LIMIT) begin
                abort_run($sformatf("Timeout: channel %0d output stopped toggling", ch));
            end
            @(negedge i_clk);
            hp++;
        end
        if (hp != new_div) begin
            check_value($sformatf("divisor change ch%0d running half", ch), old_div, hp);
        end
        for (int i = 0; i < GLITCH_HALFS; i++) begin
            measure_half(ch, hp);
            if (i > 0 || hp != old_div) begin
                check_value($sformatf("divisor change ch%0d #%0d", ch, i), new_div, hp);
            end
        end
    endtask

    task automatic check_credits();
        wait_for_drain();
        repeat (HOLD_CYCLES) @(posedge i_clk);
        check_value("credit pulses", cmds_sent, credit_pulses);
        @(negedge i_clk);
        check_value("overflow with credits kept", 0, o_overflow);
    endtask

    task automatic run_step(input logic [63:0] kind, input int ch, input int op,
                            input int value, input int expected);
        if (kind == "cmd") begin
            send_cmd(build_cmd(ch, op, value));
        end else if (kind == "raw") begin
            send_burst(build_cmd(ch, op, value), expected);
        end else if (kind == "chk") begin
            case (op)
                0: check_half_periods(ch, value, expected);
                1: check_level(ch, expected);
                2: begin
                    @(negedge i_clk);
                    check_value("overflow flag", expected, o_overflow);
                end
                3: check_div_change(ch, value, expected);
                4: check_credits();
                default: abort_run($sformatf("Unknown check type %0d in stimulus file", op));
            endcase
        end else begin
            abort_run($sformatf("Unknown step kind %s in stimulus file", kind));
        end
    endtask

    initial begin
        int               fd;
        int               n;
        int               ch;
        int               op;
        int               value;
        int               expected;
        logic [63:0]      kind;
        logic [8*256-1:0] rest;
        logic             done;
        i_clk         = 1'b0;
        i_rst_n       = 1'b0;
        i_cmd_valid   = 1'b0;
        i_cmd         = '0;
        credit_pulses = 0;
        cmds_sent     = 0;
        clk_seen      = '0;
        seed          = 44044;
        repeat (2) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        check_value("reset o_clk", 0, o_clk);
        check_value("reset o_credit", 0, o_credit);
        check_value("reset o_overflow", 0, o_overflow);
        fd = $fopen("tb/clkgen_input.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the stimulus file tb/clkgen_input.txt");
        end
        done = 1'b0;
        while (!done) begin
            n = $fscanf(fd, "%s", kind);
            if (n != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                n = $fgets(rest, fd);
            end else begin
                n = $fscanf(fd, "%d %d %d %d", ch, op, value, expected);
                if (n != 4) begin
                    abort_run("Malformed line in stimulus file");
                end
                run_step(kind, ch, op, value, expected);
            end
        end
        $fclose(fd);
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- build.f
design/clkgen_pkg.sv
design/cmd_fifo.sv
design/clkgen_regs.sv
design/clk_divider.sv
design/clkgen_top.sv
tb/tb_clkgen.sv

//--- tb/clkgen_input.txt
# Columns: kind ch op value expected. cmd op 0 sets divisor, op 1 control (bit0 enable, bit1 invert)
# chk op: 0 half-period (value halves), 1 idle level, 2 overflow, 3 change from value, 4 credits
# raw sends expected copies of the command back to back without waiting for credits
# Channel 0 at divisor 3
cmd 0 0 3 0
cmd 0 1 1 0
chk 0 0 4 3
# Divisor 0 runs as 1
cmd 1 0 0 0
cmd 1 1 1 0
chk 1 0 4 1
# Divisor 1
cmd 2 0 1 0
cmd 2 1 1 0
chk 2 0 4 1
# Divisor 7
cmd 3 0 7 0
cmd 3 1 1 0
chk 3 0 3 7
chk 0 4 0 0
# Polarity flip on a running channel
cmd 3 1 3 0
chk 3 0 3 7
# Disabled channels rest at their invert bit
cmd 3 1 2 0
chk 3 1 0 1
cmd 2 1 0 0
chk 2 1 0 0
# Divisor changes on running channels
cmd 0 0 5 0
chk 0 0 3 5
cmd 0 0 9 0
chk 0 3 5 9
cmd 0 0 12 0
chk 0 0 2 12
cmd 0 0 4 0
chk 0 3 12 4
cmd 1 0 6 0
chk 1 0 3 6
cmd 1 1 3 0
chk 1 0 3 6
chk 0 4 0 0
# Slow channel 0 so a pending divisor stalls the queue
cmd 0 1 0 0
cmd 0 0 200 0
cmd 0 1 1 0
chk 0 0 1 200
chk 0 2 0 0
raw 0 0 150 6
chk 0 2 0 1
